/* src/fe_pkg.sv */
package fe_pkg;

    localparam int PADDR_W     = 16;
    localparam int ROB_ID_W    = 4;
    localparam int IMEM_DEPTH  = 256;
    localparam int IMEM_IDX_W  = $clog2(IMEM_DEPTH);
    localparam int BHT_ENTRIES = 32;
    localparam int BHT_IDX_W   = $clog2(BHT_ENTRIES);

    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;

    typedef logic [PADDR_W-1:0]  t_paddr;
    typedef logic [ROB_ID_W-1:0] t_rob_id;

    localparam t_paddr BOOT_PC = '0; // Fetch starts here out of reset

    // One instruction word, seen as J-format or B-format
    typedef union packed {
        struct packed {
            logic       imm20;
            logic [9:0] imm10_1;
            logic       imm11;
            logic [7:0] imm19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j;
        struct packed {
            logic       imm12;
            logic [5:0] imm10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm4_1;
            logic       imm11;
            logic [6:0] opcode;
        } b;
    } t_rv_instr;

    typedef struct packed {
        logic disable_bpu; // Predict everything not-taken
    } t_chicken_bits;

    typedef struct packed {
        logic   valid;
        t_paddr addr;
    } t_fe_fb_req;

    typedef struct packed {
        logic      valid;
        t_paddr    pc;
        t_rv_instr instr;
    } t_fb_fe_rsp;

    typedef struct packed {
        logic      valid;
        t_paddr    addr;
        t_rv_instr data;
    } t_imem_wr;

    typedef struct packed {
        t_rv_instr instr;
        t_paddr    pc;
        t_paddr    pc_nxt;
    } t_instr_pkt;

    typedef struct packed {
        logic valid;
        logic nuke_fe;
    } t_nuke_pkt;

    typedef struct packed {
        logic    valid;
        t_rob_id robid;
        t_paddr  restore_pc;
    } t_br_mispred_pkt;

    typedef struct packed {
        logic   valid;
        t_paddr pc;
        logic   taken;
    } t_bpu_train_pkt;

    // Age compare relative to the oldest id in flight, wraps mod 2**ROB_ID_W
    function automatic logic f_robid_a_older_b(t_rob_id a, t_rob_id b, t_rob_id oldest);
        t_rob_id dist_a;
        t_rob_id dist_b;
        dist_a = a - oldest;
        dist_b = b - oldest;
        return dist_a < dist_b;
    endfunction

endpackage

/* src/fetch_buf.sv */
module fetch_buf (
    input  logic               clk,
    input  logic               reset,
    input  fe_pkg::t_imem_wr   imem_wr,
    input  fe_pkg::t_fe_fb_req fe_fb_req_fb0,
    output fe_pkg::t_fb_fe_rsp fb_fe_rsp_fb0
);
    import fe_pkg::*;

    // Word-addressed instruction store
    t_rv_instr mem [IMEM_DEPTH];

    logic [IMEM_IDX_W-1:0] wr_idx;
    logic [IMEM_IDX_W-1:0] rd_idx;

    logic      rsp_valid;
    t_paddr    rsp_pc;
    t_rv_instr rsp_instr;

    // Byte address to word index
    assign wr_idx = imem_wr.addr[IMEM_IDX_W+1:2];
    assign rd_idx = fe_fb_req_fb0.addr[IMEM_IDX_W+1:2];

    // Load port, one word per cycle
    always_ff @(posedge clk) begin
        if (imem_wr.valid) begin
            mem[wr_idx] <= imem_wr.data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= fe_fb_req_fb0.valid;
        end
    end

    // Payload follows every request, valid or not
    always_ff @(posedge clk) begin
        rsp_pc    <= fe_fb_req_fb0.addr;   // Echo the pc so fetch can spot stale data
        rsp_instr <= mem[rd_idx];
    end

    always_comb begin
        fb_fe_rsp_fb0.valid = rsp_valid;
        fb_fe_rsp_fb0.pc    = rsp_pc;
        fb_fe_rsp_fb0.instr = rsp_instr;
    end

endmodule

/* src/bpu.sv */
module bpu (
    input  logic                   clk,
    input  logic                   reset,
    input  fe_pkg::t_chicken_bits  chicken_bits,
    input  fe_pkg::t_paddr         pc,
    input  fe_pkg::t_rv_instr      instr,
    input  fe_pkg::t_bpu_train_pkt bpu_train_pkt_ex0,
    output logic                   pred_tkn,
    output fe_pkg::t_paddr         pred_pc_nxt
);
    import fe_pkg::*;

    // 2-bit saturating counters, 0..1 not-taken, 2..3 taken
    logic [1:0] bht [BHT_ENTRIES];

    logic [BHT_IDX_W-1:0] rd_idx;
    logic [BHT_IDX_W-1:0] tr_idx;
    logic [1:0]           rd_ctr;
    logic [1:0]           tr_ctr;

    logic        is_jal;
    logic        is_br;
    logic [31:0] j_off;
    logic [31:0] b_off;
    t_paddr      j_tgt;
    t_paddr      b_tgt;

    assign rd_idx = pc[BHT_IDX_W+1:2];
    assign tr_idx = bpu_train_pkt_ex0.pc[BHT_IDX_W+1:2];
    assign rd_ctr = bht[rd_idx];
    assign tr_ctr = bht[tr_idx];

    // Decode, same word through both views
    assign is_jal = instr.j.opcode == OP_JAL;
    assign is_br  = instr.b.opcode == OP_BRANCH;

    // Sign-extended immediates, bit 0 always zero
    assign j_off = {{11{instr.j.imm20}}, instr.j.imm20, instr.j.imm19_12,
                    instr.j.imm11, instr.j.imm10_1, 1'b0};
    assign b_off = {{19{instr.b.imm12}}, instr.b.imm12, instr.b.imm11,
                    instr.b.imm10_5, instr.b.imm4_1, 1'b0};

    assign j_tgt = pc + j_off[PADDR_W-1:0];
    assign b_tgt = pc + b_off[PADDR_W-1:0];

    always_comb begin
        pred_tkn    = 1'b0;
        pred_pc_nxt = b_tgt;
        if (is_jal) begin
            pred_tkn    = 1'b1; // Unconditional
            pred_pc_nxt = j_tgt;
        end else if (is_br) begin
            pred_tkn    = rd_ctr[1];
        end
        if (chicken_bits.disable_bpu) begin
            pred_tkn = 1'b0;
        end
    end

    // Training from execute, saturating in both directions
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < BHT_ENTRIES; i++) begin
                bht[i] <= 2'd1; // Weakly not-taken
            end
        end else if (bpu_train_pkt_ex0.valid) begin
            if (bpu_train_pkt_ex0.taken) begin
                if (tr_ctr != 2'd3) begin
                    bht[tr_idx] <= tr_ctr + 2'd1;
                end
            end else if (tr_ctr != 2'd0) begin
                bht[tr_idx] <= tr_ctr - 2'd1;
            end
        end
    end

endmodule

/* src/fe_ctl.sv */
module fe_ctl (
    input  logic                    clk,
    input  logic                    reset,

    input  fe_pkg::t_nuke_pkt       nuke_rb1,
    input  logic                    resume_fetch_rbx,
    input  fe_pkg::t_rob_id         oldest_robid,
    input  fe_pkg::t_br_mispred_pkt br_mispred_ex0,

    output fe_pkg::t_fe_fb_req      fe_fb_req_fb0,
    input  fe_pkg::t_fb_fe_rsp      fb_fe_rsp_fb0,

    output fe_pkg::t_paddr          pc,
    input  logic                    pred_tkn,
    input  fe_pkg::t_paddr          pred_pc_nxt,

    output logic                    valid_fe1,
    output fe_pkg::t_instr_pkt      instr_fe1,
    input  logic                    decode_ready_de0
);
    import fe_pkg::*;

    typedef enum logic [1:0] {
        FE_IDLE,
        FE_REQ_IC,
        FE_PDG_NUKE
    } t_fe_state;

    t_fe_state state;
    t_fe_state state_nxt;

    logic    nuke_ql;
    logic    mispred_ql;
    logic    mispred_pdg;
    t_rob_id mispred_robid;

    logic    rsp_match;
    logic    adv_pc;
    t_paddr  pc_adv;
    t_paddr  pc_tgt;
    t_paddr  pc_nxt;

    assign nuke_ql = nuke_rb1.valid & nuke_rb1.nuke_fe;

    // Only the oldest misprediction seen so far may redirect
    assign mispred_ql = br_mispred_ex0.valid &
                        (~mispred_pdg |
                         f_robid_a_older_b(br_mispred_ex0.robid, mispred_robid, oldest_robid));

    always_ff @(posedge clk) begin
        if (reset) begin
            mispred_pdg <= 1'b0;
        end else if (nuke_ql) begin
            mispred_pdg <= 1'b0;   // Nuke flushes the wrong path
        end else if (mispred_ql) begin
            mispred_pdg <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (mispred_ql) begin
            mispred_robid <= br_mispred_ex0.robid;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            FE_IDLE:     state_nxt = FE_REQ_IC;
            FE_REQ_IC:   if (mispred_pdg | nuke_ql) state_nxt = FE_PDG_NUKE;
            FE_PDG_NUKE: if (resume_fetch_rbx) state_nxt = FE_REQ_IC;
            default:     state_nxt = FE_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= FE_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // A response counts only if it belongs to the current pc
    assign rsp_match = fb_fe_rsp_fb0.valid & (fb_fe_rsp_fb0.pc == pc);
    assign valid_fe1 = (state == FE_REQ_IC) & rsp_match & ~mispred_pdg;
    assign adv_pc    = valid_fe1 & decode_ready_de0;

    // Path the current instruction continues on
    assign pc_adv = pc + t_paddr'(4);
    assign pc_tgt = pred_tkn ? pred_pc_nxt : pc_adv;

    always_comb begin
        if (reset) begin
            pc_nxt = BOOT_PC;
        end else if (mispred_ql) begin
            pc_nxt = br_mispred_ex0.restore_pc;
        end else if (adv_pc) begin
            pc_nxt = pc_tgt;    // Predicted target or pc+4
        end else begin
            pc_nxt = pc;
        end
    end

    always_ff @(posedge clk) begin
        pc <= pc_nxt;
    end

    // Request the current pc every cycle in FE_REQ_IC
    always_comb begin
        fe_fb_req_fb0.valid = state == FE_REQ_IC;
        fe_fb_req_fb0.addr  = pc;
    end

    // Held steady under back-pressure since pc and the re-read word do not move
    always_comb begin
        instr_fe1.instr  = fb_fe_rsp_fb0.instr;
        instr_fe1.pc     = fb_fe_rsp_fb0.pc;
        instr_fe1.pc_nxt = pc_tgt;
    end

endmodule

/* src/fe_top.sv */
module fe_top (
    input  logic                    clk,
    input  logic                    reset,
    input  fe_pkg::t_chicken_bits   chicken_bits,
    input  fe_pkg::t_imem_wr        imem_wr,
    input  fe_pkg::t_nuke_pkt       nuke_rb1,
    input  logic                    resume_fetch_rbx,
    input  fe_pkg::t_rob_id         oldest_robid,
    input  fe_pkg::t_br_mispred_pkt br_mispred_ex0,
    input  fe_pkg::t_bpu_train_pkt  bpu_train_pkt_ex0,
    output logic                    valid_fe1,
    output fe_pkg::t_instr_pkt      instr_fe1,
    input  logic                    decode_ready_de0
);
    import fe_pkg::*;

    t_fe_fb_req fe_fb_req_fb0;
    t_fb_fe_rsp fb_fe_rsp_fb0;
    t_paddr     pc;
    logic       pred_tkn;
    t_paddr     pred_pc_nxt;

    fe_ctl u_fe_ctl (
        .clk,
        .reset,
        .nuke_rb1,
        .resume_fetch_rbx,
        .oldest_robid,
        .br_mispred_ex0,
        .fe_fb_req_fb0,
        .fb_fe_rsp_fb0,
        .pc,
        .pred_tkn,
        .pred_pc_nxt,
        .valid_fe1,
        .instr_fe1,
        .decode_ready_de0
    );

    // Predictor looks at the word just returned for the current pc
    bpu u_bpu (
        .clk,
        .reset,
        .chicken_bits,
        .pc,
        .instr       (fb_fe_rsp_fb0.instr),
        .bpu_train_pkt_ex0,
        .pred_tkn,
        .pred_pc_nxt
    );

    fetch_buf u_fetch_buf (
        .clk,
        .reset,
        .imem_wr,
        .fe_fb_req_fb0,
        .fb_fe_rsp_fb0
    );

endmodule

/* tb/fe_clkgen.sv */
module fe_clkgen #(
    parameter int PERIOD     = 40,
    parameter int RST_CYCLES = 10
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Power-on reset, released on a rising edge
    initial begin
        reset = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

/* tb/fe_chk.sv */
module fe_chk (
    input logic                    clk,
    input logic                    reset,
    input logic                    valid_fe1,
    input logic                    decode_ready_de0,
    input fe_pkg::t_instr_pkt      instr_fe1,
    input fe_pkg::t_br_mispred_pkt br_mispred_ex0
);
    import fe_pkg::*;

    int n_fail = 0; // Assertion failures so far

    // Stalled instruction must not change under decode
    property p_hold_stable;
        @(posedge clk) disable iff (reset)
            valid_fe1 && !decode_ready_de0 |=> !valid_fe1 || $stable(instr_fe1);
    endproperty

    // Nothing offered right after a reset cycle
    property p_quiet_after_reset;
        @(posedge clk) reset |=> !valid_fe1;
    endproperty

    // A misprediction blocks delivery from the next cycle on
    property p_block_after_mispred;
        @(posedge clk) disable iff (reset)
            br_mispred_ex0.valid |=> !valid_fe1;
    endproperty

    a_hold_stable: assert property (p_hold_stable)
        else begin
            $error("instr_fe1 changed while stalled");
            n_fail++;
        end
    a_quiet_after_reset: assert property (p_quiet_after_reset)
        else begin
            $error("valid_fe1 high right after reset");
            n_fail++;
        end
    a_block_after_mispred: assert property (p_block_after_mispred)
        else begin
            $error("valid_fe1 high in the cycle after a misprediction");
            n_fail++;
        end

endmodule

/* tb/fe_tb.sv */
module fe_tb;
    import fe_pkg::*;

    localparam int N_ROWS   = 8;
    localparam int MAX_EXP  = 10;
    localparam int EV_NONE  = 0;
    localparam int EV_TRAIN = 1;
    localparam int EV_MISP  = 2;
    localparam int EV_MISP2 = 3; // Two mispredictions back to back

    typedef struct {
        string name;
        int    prog;      // 0 straight line, 1 JAL, 2 branch loop
        bit    no_bpu;
        bit    rnd_ready;
        int    evt;
        int    evt_at;    // Event starts after this many transfers
        int    rob_a;
        int    rob_b;
        int    pc_a;
        int    pc_b;
        int    oldest;
        int    n_exp;
        int    exp_pc [MAX_EXP];
    } row_t;

    logic clk;
    logic por;
    logic row_rst;
    logic reset;

    t_chicken_bits   chicken_bits;
    t_imem_wr        imem_wr;
    t_nuke_pkt       nuke_rb1;
    logic            resume_fetch_rbx;
    t_rob_id         oldest_robid;
    t_br_mispred_pkt br_mispred_ex0;
    t_bpu_train_pkt  bpu_train_pkt_ex0;
    logic            valid_fe1;
    t_instr_pkt      instr_fe1;
    logic            decode_ready_de0;

    row_t        rows [N_ROWS];
    logic [31:0] image [IMEM_DEPTH];
    int          wd_cycles = 0;

    assign reset = por | row_rst;

    fe_clkgen #(.PERIOD(40), .RST_CYCLES(10)) u_clkgen (.clk(clk), .reset(por));

    fe_top DUT (.*);

    bind fe_top fe_chk u_chk (.*);

    function automatic logic [31:0] enc_jal(int off);
        logic [20:0] o;
        o = off[20:0];
        return {o[20], o[10:1], o[11], o[19:12], 5'd0, 7'b1101111};
    endfunction

    function automatic logic [31:0] enc_branch(int off);
        logic [12:0] o;
        o = off[12:0];
        return {o[12], o[10:5], 5'd2, 5'd1, 3'd0, o[4:1], o[11], 7'b1100011};
    endfunction

    // addi x1, x0, idx keeps every word distinct
    function automatic logic [31:0] fill_word(int idx);
        logic [11:0] imm;
        imm = idx[11:0];
        return {imm, 5'd0, 3'd0, 5'd1, 7'b0010011};
    endfunction

    task automatic build_image(input int prog);
        for (int i = 0; i < IMEM_DEPTH; i++) begin
            image[i] = fill_word(i);
        end
        if (prog == 1) begin
            image[2] = enc_jal(16);
        end else if (prog == 2) begin
            image[3] = enc_branch(-8);  // Backward branch to 4
            image[4] = enc_jal(-12);    // Loop back to 4
        end
    endtask

    task automatic fill_table();
        rows[0] = '{"seq_fetch", 0, 0, 0, EV_NONE, 0, 0, 0, 0, 0, 0, 10,
                    '{0, 4, 8, 12, 16, 20, 24, 28, 32, 36}};
        rows[1] = '{"jal_taken", 1, 0, 0, EV_NONE, 0, 0, 0, 0, 0, 0, 8,
                    '{0, 4, 8, 24, 28, 32, 36, 40, 0, 0}};
        rows[2] = '{"jal_bpu_off", 1, 1, 0, EV_NONE, 0, 0, 0, 0, 0, 0, 8,
                    '{0, 4, 8, 12, 16, 20, 24, 28, 0, 0}};
        rows[3] = '{"branch_train", 2, 0, 0, EV_TRAIN, 5, 0, 0, 12, 0, 0, 10,
                    '{0, 4, 8, 12, 16, 4, 8, 12, 4, 8}};
        rows[4] = '{"mispred_one", 0, 0, 0, EV_MISP, 3, 5, 0, 'h40, 0, 3, 6,
                    '{0, 4, 8, 'h40, 'h44, 'h48, 0, 0, 0, 0}};
        rows[5] = '{"mispred_wrap_newer", 0, 0, 0, EV_MISP2, 3, 1, 15, 'h80, 'h60, 14, 6,
                    '{0, 4, 8, 'h60, 'h64, 'h68, 0, 0, 0, 0}};
        rows[6] = '{"mispred_wrap_keep", 0, 0, 0, EV_MISP2, 3, 15, 1, 'h80, 'h60, 14, 5,
                    '{0, 4, 8, 'h80, 'h84, 0, 0, 0, 0, 0}};
        rows[7] = '{"random_ready", 0, 0, 1, EV_NONE, 0, 0, 0, 0, 0, 0, 10,
                    '{0, 4, 8, 12, 16, 20, 24, 28, 32, 36}};
    endtask

    task automatic run_row(input int r, output int errs);
        int     got;
        int     step;
        bit     active;
        bit     misp;
        t_paddr exp_pc;
        errs   = 0;
        got    = 0;
        step   = 0;
        active = 1'b0;
        misp   = rows[r].evt >= EV_MISP;
        build_image(rows[r].prog);
        @(posedge clk);
        row_rst                  <= 1'b1;
        decode_ready_de0         <= 1'b0;
        chicken_bits.disable_bpu <= rows[r].no_bpu;
        oldest_robid             <= t_rob_id'(rows[r].oldest);
        for (int i = 0; i < IMEM_DEPTH; i++) begin
            @(posedge clk);
            imem_wr <= '{1'b1, t_paddr'(i * 4), image[i]};
        end
        @(posedge clk);
        imem_wr <= '0;
        @(posedge clk);
        row_rst          <= 1'b0;
        decode_ready_de0 <= 1'b1;
        while (got < rows[r].n_exp) begin
            @(posedge clk);
            if (valid_fe1 && decode_ready_de0) begin
                exp_pc = t_paddr'(rows[r].exp_pc[got]);
                assert (!(active && misp)) else begin
                    $display("Error: %s delivered pc %h while a misprediction was pending",
                             rows[r].name, instr_fe1.pc);
                    errs++;
                end
                assert (instr_fe1.pc == exp_pc) else begin
                    $display("Fail %s: pc expected %h actual %h",
                             rows[r].name, exp_pc, instr_fe1.pc);
                    errs++;
                end
                assert (instr_fe1.instr == image[exp_pc[IMEM_IDX_W+1:2]]) else begin
                    $display("Fail %s: instr expected %h actual %h", rows[r].name,
                             image[exp_pc[IMEM_IDX_W+1:2]], instr_fe1.instr);
                    errs++;
                end
                // Redirected step is not what fetch predicted
                if (got + 1 < rows[r].n_exp && !(misp && got + 1 == rows[r].evt_at)) begin
                    assert (instr_fe1.pc_nxt == t_paddr'(rows[r].exp_pc[got + 1])) else begin
                        $display("Fail %s: pc_nxt expected %h actual %h", rows[r].name,
                                 t_paddr'(rows[r].exp_pc[got + 1]), instr_fe1.pc_nxt);
                        errs++;
                    end
                end
                got++;
                if (rows[r].evt != EV_NONE && got == rows[r].evt_at) begin
                    active = 1'b1;
                    step   = 0;
                end
            end
            decode_ready_de0  <= rows[r].rnd_ready ? 1'($urandom_range(0, 1)) : 1'b1;
            bpu_train_pkt_ex0 <= '0;
            br_mispred_ex0    <= '0;
            nuke_rb1          <= '0;
            resume_fetch_rbx  <= 1'b0;
            if (active) begin
                if (rows[r].evt == EV_TRAIN) begin
                    bpu_train_pkt_ex0 <= '{1'b1, t_paddr'(rows[r].pc_a), 1'b1};
                    if (step == 1) active = 1'b0;
                end else begin
                    case (step)
                        0: br_mispred_ex0 <= '{1'b1, t_rob_id'(rows[r].rob_a),
                                               t_paddr'(rows[r].pc_a)};
                        1: if (rows[r].evt == EV_MISP2) begin
                            br_mispred_ex0 <= '{1'b1, t_rob_id'(rows[r].rob_b),
                                               t_paddr'(rows[r].pc_b)};
                        end
                        2: nuke_rb1 <= '{1'b1, 1'b1};
                        default: begin
                            resume_fetch_rbx <= 1'b1;
                            active = 1'b0;
                        end
                    endcase
                end
                step++;
            end
        end
    endtask

    // Runaway guard sized from the table
    initial begin
        wait (wd_cycles > 0);
        repeat (wd_cycles) @(posedge clk);
        $display("Watchdog: the run timed out before all tests finished");
        $display("Test failed");
        $finish;
    end

    initial begin
        int errs;
        int total_errs;
        int n_pass;
        int chk_base;
        void'($urandom(32'h0df4a26c));
        row_rst           = 1'b1;
        chicken_bits      = '0;
        imem_wr           = '0;
        nuke_rb1          = '0;
        resume_fetch_rbx  = 1'b0;
        oldest_robid      = '0;
        br_mispred_ex0    = '0;
        bpu_train_pkt_ex0 = '0;
        decode_ready_de0  = 1'b0;
        total_errs        = 0;
        n_pass            = 0;
        fill_table();
        for (int r = 0; r < N_ROWS; r++) begin
            wd_cycles += rows[r].n_exp * 8 + IMEM_DEPTH + 40;
        end
        for (int r = 0; r < N_ROWS; r++) begin
            chk_base = DUT.u_chk.n_fail;
            run_row(r, errs);
            @(posedge clk); // Let the last edge's bound assertions settle
            errs += DUT.u_chk.n_fail - chk_base;
            total_errs += errs;
            if (errs == 0) begin
                n_pass++;
                $display("fe_tb: %s ok", rows[r].name);
            end else begin
                $display("fe_tb: %s had %0d errors", rows[r].name, errs);
            end
        end
        $display("fe_tb: %0d tests, %0d ok, %0d errors", N_ROWS, n_pass, total_errs);
        if (total_errs == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* vlog.f */
src/fe_pkg.sv
src/fetch_buf.sv
src/bpu.sv
src/fe_ctl.sv
src/fe_top.sv
tb/fe_clkgen.sv
tb/fe_chk.sv
tb/fe_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
LINTFLAGS = --lint-only --timing
TOP       = fe_tb
FILELIST  = vlog.f
LOG       = sim.log
PASS_MSG  = Test completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

obj_dir/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
